// ==== design/csr_macros.svh ====
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// global sizes of the csr block
////////////////////////////////////////////////////////////////////////////

// register data width
`define CSR_XLEN 32

// cause width, top bit flags an interrupt
`define CSR_CAUSE_W 6

// number of performance counters
`define CSR_N_PERF 8

// boot address and trap vector base width
`define CSR_BOOT_W 24

`endif

// ==== design/csr_pkg.sv ====
`default_nettype none

`include "csr_macros.svh"

package csr_pkg;

  typedef logic [11:0]          csr_addr_t;
  typedef logic [`CSR_XLEN-1:0] csr_data_t;

  // access operations, encoding as issued by the decoder
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // only the writable mstatus bits are stored
  typedef struct packed {
    logic mpie;
    logic mie;
  } mstatus_t;

  ////////////////////////////////////////////////////////////////////////////
  // csr addresses
  ////////////////////////////////////////////////////////////////////////////
  localparam csr_addr_t CSR_MSTATUS     = 12'h300;
  localparam csr_addr_t CSR_MISA        = 12'h301;
  localparam csr_addr_t CSR_MTVEC       = 12'h305;
  localparam csr_addr_t CSR_MEPC        = 12'h341;
  localparam csr_addr_t CSR_MCAUSE      = 12'h342;
  localparam csr_addr_t CSR_MHARTID     = 12'hF14;
  // non-standard copy of mhartid
  localparam csr_addr_t CSR_MHARTID_DUP = 12'h014;
  localparam csr_addr_t CSR_PCER        = 12'h7A0;
  localparam csr_addr_t CSR_PCMR        = 12'h7A1;
  // write hits every counter at once
  localparam csr_addr_t CSR_PCCR_ALL    = 12'h79F;

  // mstatus field positions
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LO   = 11;
  localparam int MSTATUS_MPP_HI   = 12;
  // mpp is hardwired to machine mode
  localparam logic [1:0] MPP_MACHINE = 2'b11;

endpackage

`default_nettype wire

// ==== design/perf_pkg.sv ====
`default_nettype none

package perf_pkg;

  // counter index per event
  typedef enum logic [2:0] {
    EV_CYCLES     = 3'd0,
    EV_INSTR      = 3'd1,
    EV_LD_STALL   = 3'd2,
    EV_JR_STALL   = 3'd3,
    EV_IMISS      = 3'd4,
    EV_LOAD       = 3'd5,
    EV_STORE      = 3'd6,
    EV_COMPRESSED = 3'd7
  } perf_event_e;

  // counters sit in the 32-entry window 780..79f
  localparam csr_pkg::csr_addr_t PCCR_BASE   = 12'h780;
  localparam logic [6:0]         PCCR_PREFIX = PCCR_BASE[11:5];

  // pcmr bits, global enable and saturate
  localparam int         PCMR_EN_BIT  = 0;
  localparam int         PCMR_SAT_BIT = 1;
  localparam logic [1:0] PCMR_RESET   = 2'b11;

endpackage

`default_nettype wire

// ==== design/csr_access_unit.sv ====
`default_nettype none

`include "csr_macros.svh"

module csr_access_unit (
  input  wire logic                                  csr_access_i,
  input  wire csr_pkg::csr_addr_t                    csr_addr_i,
  input  wire csr_pkg::csr_data_t                    csr_wdata_i,
  input  wire csr_pkg::csr_op_e                      csr_op_i,
  input  wire logic [3:0]                            core_id_i,
  input  wire logic [5:0]                            cluster_id_i,
  input  wire logic [`CSR_BOOT_W-1:0]                boot_addr_i,
  input  wire csr_pkg::mstatus_t                     mstatus_i,
  input  wire csr_pkg::csr_data_t                    mepc_i,
  input  wire logic [`CSR_CAUSE_W-1:0]               mcause_i,
  input  wire logic [`CSR_N_PERF-1:0]                pcer_i,
  input  wire logic [1:0]                            pcmr_i,
  input  wire logic [`CSR_N_PERF-1:0][`CSR_XLEN-1:0] pccr_i,
  output csr_pkg::csr_data_t                         csr_rdata_o,
  output csr_pkg::csr_data_t                         csr_wdata_o,
  output logic                                       mstatus_we_o,
  output logic                                       mepc_we_o,
  output logic                                       mcause_we_o,
  output logic                                       pcer_we_o,
  output logic                                       pcmr_we_o,
  output logic                                       pccr_we_o,
  output logic [$clog2(`CSR_N_PERF)-1:0]             pccr_idx_o,
  output logic                                       pccr_all_o
);

  localparam int IDX_W = $clog2(`CSR_N_PERF);

  logic [IDX_W-1:0] cnt_idx;
  logic             is_pccr;
  logic             is_pccr_all;
  logic             wr_en;

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  assign cnt_idx = csr_addr_i[IDX_W-1:0];
  // inside the counter window and below the implemented count
  assign is_pccr = (csr_addr_i[11:5] == perf_pkg::PCCR_PREFIX) &&
                   (csr_addr_i[4:0] < `CSR_N_PERF);
  assign is_pccr_all = (csr_addr_i == csr_pkg::CSR_PCCR_ALL);

  // no write for op none
  assign wr_en = csr_access_i && (csr_op_i != csr_pkg::CSR_OP_NONE);

  // read mux, unused addresses give zero
  always_comb begin
    csr_rdata_o = '0;
    case (csr_addr_i)
      csr_pkg::CSR_MSTATUS: begin
        csr_rdata_o[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] = csr_pkg::MPP_MACHINE;
        csr_rdata_o[csr_pkg::MSTATUS_MPIE_BIT] = mstatus_i.mpie;
        csr_rdata_o[csr_pkg::MSTATUS_MIE_BIT]  = mstatus_i.mie;
      end
      // no isa id allocated
      csr_pkg::CSR_MISA: csr_rdata_o = '0;
      // vector base is the boot address
      csr_pkg::CSR_MTVEC: csr_rdata_o = {boot_addr_i, {(`CSR_XLEN-`CSR_BOOT_W){1'b0}}};
      csr_pkg::CSR_MEPC: csr_rdata_o = mepc_i;
      csr_pkg::CSR_MCAUSE: begin
        csr_rdata_o[`CSR_XLEN-1]      = mcause_i[`CSR_CAUSE_W-1];
        csr_rdata_o[`CSR_CAUSE_W-2:0] = mcause_i[`CSR_CAUSE_W-2:0];
      end
      csr_pkg::CSR_MHARTID, csr_pkg::CSR_MHARTID_DUP: begin
        csr_rdata_o[10:5] = cluster_id_i;
        csr_rdata_o[3:0]  = core_id_i;
      end
      csr_pkg::CSR_PCER: csr_rdata_o[`CSR_N_PERF-1:0] = pcer_i;
      csr_pkg::CSR_PCMR: csr_rdata_o[1:0] = pcmr_i;
      default: begin
        if (is_pccr) begin
          csr_rdata_o = pccr_i[cnt_idx];
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // operation and write strobes
  ////////////////////////////////////////////////////////////////////////////

  // set and clear modify the current read value
  always_comb begin
    case (csr_op_i)
      csr_pkg::CSR_OP_SET:   csr_wdata_o = csr_wdata_i | csr_rdata_o;
      csr_pkg::CSR_OP_CLEAR: csr_wdata_o = ~csr_wdata_i & csr_rdata_o;
      default:               csr_wdata_o = csr_wdata_i;
    endcase
  end

  assign mstatus_we_o = wr_en && (csr_addr_i == csr_pkg::CSR_MSTATUS);
  assign mepc_we_o    = wr_en && (csr_addr_i == csr_pkg::CSR_MEPC);
  assign mcause_we_o  = wr_en && (csr_addr_i == csr_pkg::CSR_MCAUSE);
  assign pcer_we_o    = wr_en && (csr_addr_i == csr_pkg::CSR_PCER);
  assign pcmr_we_o    = wr_en && (csr_addr_i == csr_pkg::CSR_PCMR);
  // 79f reads zero, so set and clear act on zero
  assign pccr_we_o    = wr_en && (is_pccr || is_pccr_all);
  assign pccr_all_o   = wr_en && is_pccr_all;
  assign pccr_idx_o   = cnt_idx;

endmodule

`default_nettype wire

// ==== design/trap_ctrl.sv ====
`default_nettype none

`include "csr_macros.svh"

module trap_ctrl (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire csr_pkg::csr_data_t      csr_wdata_i,
  input  wire logic                    mstatus_we_i,
  input  wire logic                    mepc_we_i,
  input  wire logic                    mcause_we_i,
  input  wire csr_pkg::csr_data_t      pc_if_i,
  input  wire csr_pkg::csr_data_t      pc_id_i,
  input  wire logic                    exc_save_if_i,
  input  wire logic                    exc_save_id_i,
  input  wire logic                    save_exc_cause_i,
  input  wire logic [`CSR_CAUSE_W-1:0] exc_cause_i,
  input  wire logic                    exc_restore_mret_i,
  output csr_pkg::mstatus_t            mstatus_o,
  output csr_pkg::csr_data_t           mepc_o,
  output logic [`CSR_CAUSE_W-1:0]      mcause_o,
  output logic                         irq_enable_o,
  output csr_pkg::csr_data_t           epc_o
);

  csr_pkg::mstatus_t           mstatus_q;
  csr_pkg::mstatus_t           mstatus_d;
  csr_pkg::csr_data_t          mepc_q;
  csr_pkg::csr_data_t          mepc_d;
  csr_pkg::csr_data_t          exc_pc;
  logic [`CSR_CAUSE_W-1:0]     mcause_q;
  logic [`CSR_CAUSE_W-1:0]     mcause_d;

  // pc to save, if stage takes priority
  always_comb begin
    exc_pc = pc_id_i;
    if (exc_save_if_i) begin
      exc_pc = pc_if_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // next state, trap and mret over csr writes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_d = mstatus_q;
    mepc_d    = mepc_q;
    mcause_d  = mcause_q;

    // software writes
    if (mstatus_we_i) begin
      mstatus_d.mie  = csr_wdata_i[csr_pkg::MSTATUS_MIE_BIT];
      mstatus_d.mpie = csr_wdata_i[csr_pkg::MSTATUS_MPIE_BIT];
    end
    if (mepc_we_i) begin
      mepc_d = csr_wdata_i;
    end
    // interrupt flag from bit 31, same layout as the read word
    if (mcause_we_i) begin
      mcause_d = {csr_wdata_i[`CSR_XLEN-1], csr_wdata_i[`CSR_CAUSE_W-2:0]};
    end

    if (save_exc_cause_i) begin
      // trap entry, stack the enable
      mstatus_d.mpie = mstatus_q.mie;
      mstatus_d.mie  = 1'b0;
      mepc_d         = exc_pc;
      mcause_d       = exc_cause_i;
    end else if (exc_restore_mret_i) begin
      // mret, pop the enable
      mstatus_d.mie  = mstatus_q.mpie;
      mstatus_d.mpie = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      mstatus_q <= mstatus_d;
      mepc_q    <= mepc_d;
      mcause_q  <= mcause_d;
    end
  end

  assign mstatus_o    = mstatus_q;
  assign mepc_o       = mepc_q;
  assign mcause_o     = mcause_q;
  assign irq_enable_o = mstatus_q.mie;
  // return target for mret
  assign epc_o        = mepc_q;

endmodule

`default_nettype wire

// ==== design/perf_counters.sv ====
`default_nettype none

`include "csr_macros.svh"

module perf_counters (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire csr_pkg::csr_data_t        csr_wdata_i,
  input  wire logic                      pcer_we_i,
  input  wire logic                      pcmr_we_i,
  input  wire logic                      pccr_we_i,
  input  wire logic [$clog2(`CSR_N_PERF)-1:0] pccr_idx_i,
  input  wire logic                      pccr_all_i,
  input  wire logic                      id_valid_i,
  input  wire logic                      is_decoding_i,
  input  wire logic                      is_compressed_i,
  input  wire logic                      ld_stall_i,
  input  wire logic                      jr_stall_i,
  input  wire logic                      imiss_i,
  input  wire logic                      pc_set_i,
  input  wire logic                      mem_load_i,
  input  wire logic                      mem_store_i,
  output logic [`CSR_N_PERF-1:0]         pcer_o,
  output logic [1:0]                     pcmr_o,
  output logic [`CSR_N_PERF-1:0][`CSR_XLEN-1:0] pccr_o
);

  localparam int N     = `CSR_N_PERF;
  localparam int IDX_W = $clog2(N);

  logic                    id_valid_q;
  logic [N-1:0]            evt;
  logic [N-1:0]            inc;
  logic [N-1:0]            inc_q;
  logic [N-1:0]            pcer_q;
  logic [1:0]              pcmr_q;
  csr_pkg::csr_data_t      cnt_q [N];
  csr_pkg::csr_data_t      cnt_d [N];

  ////////////////////////////////////////////////////////////////////////////
  // event conditions
  ////////////////////////////////////////////////////////////////////////////

  assign evt[perf_pkg::EV_CYCLES]     = 1'b1;
  assign evt[perf_pkg::EV_INSTR]      = id_valid_i & is_decoding_i;
  // stalls count only after the stage was valid
  assign evt[perf_pkg::EV_LD_STALL]   = ld_stall_i & id_valid_q;
  assign evt[perf_pkg::EV_JR_STALL]   = jr_stall_i & id_valid_q;
  // fetch wait, jumps and branches excluded
  assign evt[perf_pkg::EV_IMISS]      = imiss_i & ~pc_set_i;
  assign evt[perf_pkg::EV_LOAD]       = mem_load_i;
  assign evt[perf_pkg::EV_STORE]      = mem_store_i;
  assign evt[perf_pkg::EV_COMPRESSED] = id_valid_i & is_decoding_i & is_compressed_i;

  // per-counter and global enable
  assign inc = evt & pcer_q & {N{pcmr_q[perf_pkg::PCMR_EN_BIT]}};

  ////////////////////////////////////////////////////////////////////////////
  // counter update
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < N; i++) begin
      cnt_d[i] = cnt_q[i];
      if (pccr_we_i && (pccr_all_i || (pccr_idx_i == IDX_W'(i)))) begin
        // csr write replaces the increment
        cnt_d[i] = csr_wdata_i;
      end else if (inc_q[i] && !(pcmr_q[perf_pkg::PCMR_SAT_BIT] && (&cnt_q[i]))) begin
        // wraps unless saturation holds it at all ones
        cnt_d[i] = cnt_q[i] + csr_pkg::csr_data_t'(1);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
      pcer_q     <= '0;
      pcmr_q     <= perf_pkg::PCMR_RESET;
      for (int i = 0; i < N; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      id_valid_q <= id_valid_i;
      inc_q      <= inc;
      if (pcer_we_i) begin
        pcer_q <= csr_wdata_i[N-1:0];
      end
      if (pcmr_we_i) begin
        pcmr_q <= csr_wdata_i[1:0];
      end
      for (int i = 0; i < N; i++) begin
        cnt_q[i] <= cnt_d[i];
      end
    end
  end

  assign pcer_o = pcer_q;
  assign pcmr_o = pcmr_q;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      pccr_o[i] = cnt_q[i];
    end
  end

endmodule

`default_nettype wire

// ==== design/csr_top.sv ====
`default_nettype none

`include "csr_macros.svh"

module csr_top (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  // csr access port
  input  wire logic                    csr_access_i,
  input  wire csr_pkg::csr_addr_t      csr_addr_i,
  input  wire csr_pkg::csr_data_t      csr_wdata_i,
  input  wire csr_pkg::csr_op_e        csr_op_i,
  output csr_pkg::csr_data_t           csr_rdata_o,
  // identity and boot
  input  wire logic [3:0]              core_id_i,
  input  wire logic [5:0]              cluster_id_i,
  input  wire logic [`CSR_BOOT_W-1:0]  boot_addr_i,
  // trap control
  input  wire csr_pkg::csr_data_t      pc_if_i,
  input  wire csr_pkg::csr_data_t      pc_id_i,
  input  wire logic                    exc_save_if_i,
  input  wire logic                    exc_save_id_i,
  input  wire logic                    save_exc_cause_i,
  input  wire logic [`CSR_CAUSE_W-1:0] exc_cause_i,
  input  wire logic                    exc_restore_mret_i,
  // performance events
  input  wire logic                    id_valid_i,
  input  wire logic                    is_decoding_i,
  input  wire logic                    is_compressed_i,
  input  wire logic                    ld_stall_i,
  input  wire logic                    jr_stall_i,
  input  wire logic                    imiss_i,
  input  wire logic                    pc_set_i,
  input  wire logic                    mem_load_i,
  input  wire logic                    mem_store_i,
  // to the core
  output logic                         irq_enable_o,
  output csr_pkg::csr_data_t           epc_o
);

  // operation result and strobes
  csr_pkg::csr_data_t                     op_wdata;
  logic                                   mstatus_we;
  logic                                   mepc_we;
  logic                                   mcause_we;
  logic                                   pcer_we;
  logic                                   pcmr_we;
  logic                                   pccr_we;
  logic [$clog2(`CSR_N_PERF)-1:0]         pccr_idx;
  logic                                   pccr_all;

  // register values back to the read mux
  csr_pkg::mstatus_t                      mstatus;
  csr_pkg::csr_data_t                     mepc;
  logic [`CSR_CAUSE_W-1:0]                mcause;
  logic [`CSR_N_PERF-1:0]                 pcer;
  logic [1:0]                             pcmr;
  logic [`CSR_N_PERF-1:0][`CSR_XLEN-1:0]  pccr;

  // matching names connect implicitly
  csr_access_unit u_access (
    .*,
    .mstatus_i    (mstatus),
    .mepc_i       (mepc),
    .mcause_i     (mcause),
    .pcer_i       (pcer),
    .pcmr_i       (pcmr),
    .pccr_i       (pccr),
    .csr_wdata_o  (op_wdata),
    .mstatus_we_o (mstatus_we),
    .mepc_we_o    (mepc_we),
    .mcause_we_o  (mcause_we),
    .pcer_we_o    (pcer_we),
    .pcmr_we_o    (pcmr_we),
    .pccr_we_o    (pccr_we),
    .pccr_idx_o   (pccr_idx),
    .pccr_all_o   (pccr_all)
  );

  // takes the op result, never the raw write data
  trap_ctrl u_trap (
    .*,
    .csr_wdata_i  (op_wdata),
    .mstatus_we_i (mstatus_we),
    .mepc_we_i    (mepc_we),
    .mcause_we_i  (mcause_we),
    .mstatus_o    (mstatus),
    .mepc_o       (mepc),
    .mcause_o     (mcause)
  );

  perf_counters u_perf (
    .*,
    .csr_wdata_i  (op_wdata),
    .pcer_we_i    (pcer_we),
    .pcmr_we_i    (pcmr_we),
    .pccr_we_i    (pccr_we),
    .pccr_idx_i   (pccr_idx),
    .pccr_all_i   (pccr_all),
    .pcer_o       (pcer),
    .pcmr_o       (pcmr),
    .pccr_o       (pccr)
  );

endmodule

`default_nettype wire

// ==== sim/csr_chk.sv ====
`default_nettype none

module csr_chk (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic save_i,
  input  wire logic mret_i,
  input  wire logic mie_i,
  input  wire logic irq_enable_i
);

  // failed assertions so far, read by the testbench top
  int fail_count;

  initial begin
    fail_count = 0;
  end

  // trap entry always drops the enable
  a_entry_clears_mie: assert property (
    @(posedge clk) disable iff (!rst_n) save_i |=> !mie_i
  ) else begin
    $error("mie still set one cycle after trap entry");
    fail_count++;
  end

  // core never asks for entry and mret together
  a_entry_mret_excl: assert property (
    @(posedge clk) disable iff (!rst_n) !(save_i && mret_i)
  ) else begin
    $error("trap entry and mret in the same cycle");
    fail_count++;
  end

  // interrupts off right out of reset
  a_irq_off_at_release: assert property (
    @(posedge clk) $rose(rst_n) |-> !irq_enable_i
  ) else begin
    $error("irq_enable_o high after reset release");
    fail_count++;
  end

endmodule

`default_nettype wire

// ==== sim/csr_monitor.sv ====
`default_nettype none

`include "csr_macros.svh"

module csr_monitor (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    csr_access_i,
  input  wire csr_pkg::csr_addr_t      csr_addr_i,
  input  wire csr_pkg::csr_data_t      csr_wdata_i,
  input  wire csr_pkg::csr_op_e        csr_op_i,
  input  wire logic [3:0]              core_id_i,
  input  wire logic [5:0]              cluster_id_i,
  input  wire logic [`CSR_BOOT_W-1:0]  boot_addr_i,
  input  wire csr_pkg::csr_data_t      pc_if_i,
  input  wire csr_pkg::csr_data_t      pc_id_i,
  input  wire logic                    exc_save_if_i,
  input  wire logic                    exc_save_id_i,
  input  wire logic                    save_exc_cause_i,
  input  wire logic [`CSR_CAUSE_W-1:0] exc_cause_i,
  input  wire logic                    exc_restore_mret_i,
  input  wire logic                    id_valid_i,
  input  wire logic                    is_decoding_i,
  input  wire logic                    is_compressed_i,
  input  wire logic                    ld_stall_i,
  input  wire logic                    jr_stall_i,
  input  wire logic                    imiss_i,
  input  wire logic                    pc_set_i,
  input  wire logic                    mem_load_i,
  input  wire logic                    mem_store_i,
  input  wire csr_pkg::csr_data_t      dut_rdata_i,
  input  wire logic                    dut_irq_enable_i,
  input  wire csr_pkg::csr_data_t      dut_epc_i,
  output int                           rdata_errs_o,
  output int                           irq_errs_o,
  output int                           epc_errs_o
);

  localparam int N = `CSR_N_PERF;

  // model state
  logic                    m_mie;
  logic                    m_mpie;
  csr_pkg::csr_data_t      m_mepc;
  logic [`CSR_CAUSE_W-1:0] m_mcause;
  logic [N-1:0]            m_pcer;
  logic [1:0]              m_pcmr;
  csr_pkg::csr_data_t      m_cnt [N];
  // increments registered one edge before they land
  logic [N-1:0]            m_inc_q;
  logic                    m_idv_q;

  ////////////////////////////////////////////////////////////////////////////
  // expected read word for the current address
  ////////////////////////////////////////////////////////////////////////////

  function automatic csr_pkg::csr_data_t expected_read();
    csr_pkg::csr_data_t v;
    v = '0;
    case (csr_addr_i)
      csr_pkg::CSR_MSTATUS: begin
        // mpp reads as machine mode
        v[12:11] = 2'b11;
        v[7]     = m_mpie;
        v[3]     = m_mie;
      end
      csr_pkg::CSR_MTVEC: v = {boot_addr_i, 8'h00};
      csr_pkg::CSR_MEPC: v = m_mepc;
      csr_pkg::CSR_MCAUSE: begin
        v[31]  = m_mcause[5];
        v[4:0] = m_mcause[4:0];
      end
      csr_pkg::CSR_MHARTID, csr_pkg::CSR_MHARTID_DUP: begin
        v[10:5] = cluster_id_i;
        v[3:0]  = core_id_i;
      end
      csr_pkg::CSR_PCER: v[N-1:0] = m_pcer;
      csr_pkg::CSR_PCMR: v[1:0] = m_pcmr;
      default: begin
        // counters at 780..787, rest of the window reads zero
        if (csr_addr_i[11:3] == 9'h0F0) begin
          v = m_cnt[csr_addr_i[2:0]];
        end
      end
    endcase
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // compare, then step the model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    csr_pkg::csr_data_t rd;
    csr_pkg::csr_data_t res;
    logic               we;
    logic               mie_old;
    logic               mpie_old;
    logic [N-1:0]       evt;
    logic               hit;
    if (!rst_n) begin
      m_mie        = 1'b0;
      m_mpie       = 1'b0;
      m_mepc       = '0;
      m_mcause     = '0;
      m_pcer       = '0;
      m_pcmr       = 2'b11;
      m_inc_q      = '0;
      m_idv_q      = 1'b0;
      rdata_errs_o = 0;
      irq_errs_o   = 0;
      epc_errs_o   = 0;
      for (int i = 0; i < N; i++) begin
        m_cnt[i] = '0;
      end
    end else begin
      rd = expected_read();
      if (dut_rdata_i !== rd) begin
        $display("[ERROR] %0t csr_rdata_o addr %h: expected %h, actual %h",
                 $time, csr_addr_i, rd, dut_rdata_i);
        rdata_errs_o++;
      end
      if (dut_irq_enable_i !== m_mie) begin
        $display("[ERROR] %0t irq_enable_o: expected %b, actual %b",
                 $time, m_mie, dut_irq_enable_i);
        irq_errs_o++;
      end
      if (dut_epc_i !== m_mepc) begin
        $display("[ERROR] %0t epc_o: expected %h, actual %h", $time, m_mepc, dut_epc_i);
        epc_errs_o++;
      end

      // operation result against the read value
      case (csr_op_i)
        csr_pkg::CSR_OP_SET:   res = csr_wdata_i | rd;
        csr_pkg::CSR_OP_CLEAR: res = ~csr_wdata_i & rd;
        default:               res = csr_wdata_i;
      endcase
      we       = csr_access_i && (csr_op_i != csr_pkg::CSR_OP_NONE);
      mie_old  = m_mie;
      mpie_old = m_mpie;

      // software writes first
      if (we && (csr_addr_i == csr_pkg::CSR_MSTATUS)) begin
        m_mie  = res[3];
        m_mpie = res[7];
      end
      if (we && (csr_addr_i == csr_pkg::CSR_MEPC)) begin
        m_mepc = res;
      end
      if (we && (csr_addr_i == csr_pkg::CSR_MCAUSE)) begin
        m_mcause = {res[31], res[4:0]};
      end
      // trap entry or mret wins
      if (save_exc_cause_i) begin
        m_mpie   = mie_old;
        m_mie    = 1'b0;
        m_mepc   = exc_save_if_i ? pc_if_i : pc_id_i;
        m_mcause = exc_cause_i;
      end else if (exc_restore_mret_i) begin
        m_mie  = mpie_old;
        m_mpie = 1'b1;
      end

      // gated events, enables of this cycle
      evt[0] = 1'b1;
      evt[1] = id_valid_i & is_decoding_i;
      evt[2] = ld_stall_i & m_idv_q;
      evt[3] = jr_stall_i & m_idv_q;
      evt[4] = imiss_i & ~pc_set_i;
      evt[5] = mem_load_i;
      evt[6] = mem_store_i;
      evt[7] = id_valid_i & is_decoding_i & is_compressed_i;

      for (int i = 0; i < N; i++) begin
        hit = we && ((csr_addr_i == csr_pkg::CSR_PCCR_ALL) ||
                     ((csr_addr_i[11:3] == 9'h0F0) && (csr_addr_i[2:0] == 3'(i))));
        if (hit) begin
          m_cnt[i] = res;
        end else if (m_inc_q[i] && !(m_pcmr[1] && (m_cnt[i] == 32'hFFFF_FFFF))) begin
          m_cnt[i] = m_cnt[i] + 32'd1;
        end
      end

      m_inc_q = evt & m_pcer & {N{m_pcmr[0]}};
      m_idv_q = id_valid_i;
      if (we && (csr_addr_i == csr_pkg::CSR_PCER)) begin
        m_pcer = res[N-1:0];
      end
      if (we && (csr_addr_i == csr_pkg::CSR_PCMR)) begin
        m_pcmr = res[1:0];
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_csr.sv ====
`default_nettype none

`include "csr_macros.svh"

module tb_csr;

  localparam int N_CYCLES      = 3000;
  localparam int RESET_TIMEOUT = 20;

  logic                    clk;
  logic                    rst_n;
  logic                    csr_access_i;
  csr_pkg::csr_addr_t      csr_addr_i;
  csr_pkg::csr_data_t      csr_wdata_i;
  csr_pkg::csr_op_e        csr_op_i;
  csr_pkg::csr_data_t      csr_rdata_o;
  logic [3:0]              core_id_i;
  logic [5:0]              cluster_id_i;
  logic [`CSR_BOOT_W-1:0]  boot_addr_i;
  csr_pkg::csr_data_t      pc_if_i;
  csr_pkg::csr_data_t      pc_id_i;
  logic                    exc_save_if_i;
  logic                    exc_save_id_i;
  logic                    save_exc_cause_i;
  logic [`CSR_CAUSE_W-1:0] exc_cause_i;
  logic                    exc_restore_mret_i;
  logic                    id_valid_i;
  logic                    is_decoding_i;
  logic                    is_compressed_i;
  logic                    ld_stall_i;
  logic                    jr_stall_i;
  logic                    imiss_i;
  logic                    pc_set_i;
  logic                    mem_load_i;
  logic                    mem_store_i;
  logic                    irq_enable_o;
  csr_pkg::csr_data_t      epc_o;

  logic [15:0] lfsr_q;
  int          rdata_errs;
  int          irq_errs;
  int          epc_errs;
  int          assert_fails;
  int          total_errs;

  csr_top uut (.*);

  csr_monitor mon (
    .*,
    .dut_rdata_i      (csr_rdata_o),
    .dut_irq_enable_i (irq_enable_o),
    .dut_epc_i        (epc_o),
    .rdata_errs_o     (rdata_errs),
    .irq_errs_o       (irq_errs),
    .epc_errs_o       (epc_errs)
  );

  // assertions on every trap_ctrl
  bind trap_ctrl csr_chk chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .save_i       (save_exc_cause_i),
    .mret_i       (exc_restore_mret_i),
    .mie_i        (mstatus_q.mie),
    .irq_enable_i (irq_enable_o)
  );

  initial begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;

  // two cycles of reset, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  task automatic apply_read(input csr_pkg::csr_addr_t addr);
    @(negedge clk);
    csr_access_i = 1'b0;
    csr_op_i     = csr_pkg::CSR_OP_NONE;
    csr_addr_i   = addr;
  endtask

  task automatic randomize_inputs();
    logic [31:0] r;
    logic [31:0] sub;
    take_bits(2, r);
    csr_access_i = (r[1:0] != 2'b00);
    take_bits(2, r);
    csr_op_i = csr_pkg::csr_op_e'(r[1:0]);
    // implemented addresses, plus a few holes
    take_bits(4, r);
    case (r[3:0])
      4'd0, 4'd12: csr_addr_i = csr_pkg::CSR_MSTATUS;
      4'd1:        csr_addr_i = csr_pkg::CSR_MISA;
      4'd2:        csr_addr_i = csr_pkg::CSR_MTVEC;
      4'd3:        csr_addr_i = csr_pkg::CSR_MEPC;
      4'd4:        csr_addr_i = csr_pkg::CSR_MCAUSE;
      4'd5:        csr_addr_i = csr_pkg::CSR_MHARTID;
      4'd6:        csr_addr_i = csr_pkg::CSR_MHARTID_DUP;
      4'd7:        csr_addr_i = csr_pkg::CSR_PCER;
      4'd8:        csr_addr_i = csr_pkg::CSR_PCMR;
      4'd9:        csr_addr_i = csr_pkg::CSR_PCCR_ALL;
      4'd10:       csr_addr_i = 12'h788;
      4'd11:       csr_addr_i = 12'h79E;
      4'd13:       csr_addr_i = 12'h123;
      default: begin
        take_bits(3, sub);
        csr_addr_i = {9'h0F0, sub[2:0]};
      end
    endcase
    // all ones often, to reach saturation
    take_bits(2, r);
    if (r[1:0] == 2'b00) begin
      csr_wdata_i = '1;
    end else begin
      take_bits(32, r);
      csr_wdata_i = r;
    end
    take_bits(4, r);
    core_id_i = r[3:0];
    take_bits(6, r);
    cluster_id_i = r[5:0];
    take_bits(24, r);
    boot_addr_i = r[23:0];
    // entry and mret from one draw, never both
    take_bits(3, r);
    save_exc_cause_i   = (r[2:0] == 3'd0);
    exc_restore_mret_i = (r[2:0] == 3'd1);
    take_bits(1, r);
    exc_save_if_i = r[0];
    exc_save_id_i = ~r[0];
    take_bits(32, r);
    pc_if_i = r;
    take_bits(32, r);
    pc_id_i = r;
    take_bits(6, r);
    exc_cause_i = r[5:0];
    take_bits(9, r);
    id_valid_i      = r[0];
    is_decoding_i   = r[1];
    is_compressed_i = r[2];
    ld_stall_i      = r[3];
    jr_stall_i      = r[4];
    imiss_i         = r[5];
    pc_set_i        = r[6];
    mem_load_i      = r[7];
    mem_store_i     = r[8];
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int wait_cnt;
    lfsr_q             = 16'd80;
    csr_access_i       = 1'b0;
    csr_addr_i         = '0;
    csr_wdata_i        = '0;
    csr_op_i           = csr_pkg::CSR_OP_NONE;
    core_id_i          = '0;
    cluster_id_i       = '0;
    boot_addr_i        = '0;
    pc_if_i            = '0;
    pc_id_i            = '0;
    exc_save_if_i      = 1'b0;
    exc_save_id_i      = 1'b0;
    save_exc_cause_i   = 1'b0;
    exc_cause_i        = '0;
    exc_restore_mret_i = 1'b0;
    id_valid_i         = 1'b0;
    is_decoding_i      = 1'b0;
    is_compressed_i    = 1'b0;
    ld_stall_i         = 1'b0;
    jr_stall_i         = 1'b0;
    imiss_i            = 1'b0;
    pc_set_i           = 1'b0;
    mem_load_i         = 1'b0;
    mem_store_i        = 1'b0;

    wait_cnt = 0;
    while ((rst_n !== 1'b1) && (wait_cnt < RESET_TIMEOUT)) begin
      @(negedge clk);
      wait_cnt++;
    end

    if (rst_n !== 1'b1) begin
      $display("timeout: reset not released within %0d cycles", RESET_TIMEOUT);
      $display("Verification failed");
      $finish;
    end else begin
      // reset values read back
      apply_read(csr_pkg::CSR_MSTATUS);
      apply_read(csr_pkg::CSR_MEPC);
      apply_read(csr_pkg::CSR_MCAUSE);
      apply_read(csr_pkg::CSR_PCER);
      apply_read(csr_pkg::CSR_PCMR);
      for (int c = 0; c < N_CYCLES; c++) begin
        @(negedge clk);
        randomize_inputs();
      end
      // last drive still gets compared
      @(negedge clk);
      assert_fails = uut.u_trap.chk.fail_count;
      total_errs   = rdata_errs + irq_errs + epc_errs + assert_fails;
      $display("error counts: csr_rdata_o %0d, irq_enable_o %0d, epc_o %0d, assertions %0d",
               rdata_errs, irq_errs, epc_errs, assert_fails);
      if (total_errs == 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+design
design/csr_pkg.sv
design/perf_pkg.sv
design/csr_access_unit.sv
design/trap_ctrl.sv
design/perf_counters.sv
design/csr_top.sv
sim/csr_chk.sv
sim/csr_monitor.sv
sim/tb_csr.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f --top-module tb_csr --Mdir obj_dir -o Vtb_csr
	out="$$(./obj_dir/Vtb_csr +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
